//--- all.f
vdp_cmd_pkg.sv
vdp_cmd_regs.sv
vdp_cmd_engine.sv
vdp_pixel_alu.sv
vdp_vram_port.sv
vdp_cmd_top.sv
vdp_cmd_props.sv
tb_vdp_cmd_checker.sv
tb_vdp_cmd.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vdp_cmd -f all.f -o sim_vdp_cmd

if ! ./obj_dir/sim_vdp_cmd > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

//--- tb_vdp_cmd.sv
// Testbench top for the drawing-command engine
// Clock, reset, VRAM responder, random commands and a watchdog; checker does the comparing

`timescale 1ns/1ps

module tb_vdp_cmd
  import vdp_cmd_pkg::*;
();

  localparam int NUM_CMDS = 40;

  logic        clk;
  logic        reset;
  logic        mode_8bpp;
  logic        reg_wr_req;
  logic [3:0]  reg_num;
  logic [7:0]  reg_data;
  logic        vram_rd_ack;
  logic        vram_wr_ack;
  colour_t     vram_rd_data;
  logic        reg_wr_ack;
  logic        vram_rd_req;
  logic        vram_wr_req;
  vram_addr_t  vram_addr;
  colour_t     vram_wr_data;
  logic        ce;
  colour_t     clr;
  logic [3:0]  current_command;
  colour_t     vram [0:131071];
  int          tb_errors;
  int          cur_cmd;
  int unsigned cycle_count = 0;
  int unsigned deadline    = 200;

  vdp_cmd_top u_dut (
    .clk             (clk),
    .reset           (reset),
    .mode_8bpp       (mode_8bpp),
    .reg_wr_req      (reg_wr_req),
    .reg_num         (reg_num),
    .reg_data        (reg_data),
    .vram_rd_ack     (vram_rd_ack),
    .vram_wr_ack     (vram_wr_ack),
    .vram_rd_data    (vram_rd_data),
    .reg_wr_ack      (reg_wr_ack),
    .vram_rd_req     (vram_rd_req),
    .vram_wr_req     (vram_wr_req),
    .vram_addr       (vram_addr),
    .vram_wr_data    (vram_wr_data),
    .ce              (ce),
    .clr             (clr),
    .current_command (current_command)
  );

  tb_vdp_cmd_checker u_chk (
    .clk          (clk),
    .reset        (reset),
    .mode_8bpp    (mode_8bpp),
    .reg_wr_ack   (reg_wr_ack),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .vram_wr_req  (vram_wr_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .ce           (ce),
    .clr          (clr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Deadline is moved forward by every command
  initial begin
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > deadline) begin
        $display("Watchdog timeout in command %0d at cycle %0d", cur_cmd, cycle_count);
        $display("Done: errors found");
        $finish;
      end
    end
  end

  // VRAM read side with 0 to 3 cycles of latency
  initial begin
    forever begin
      @(negedge clk);
      if (!reset && vram_rd_req != vram_rd_ack) begin
        repeat ($urandom % 4) @(negedge clk);
        vram_rd_data = vram[vram_addr];
        vram_rd_ack  = vram_rd_req;
      end
    end
  end

  // VRAM write side
  initial begin
    forever begin
      @(negedge clk);
      if (!reset && vram_wr_req != vram_wr_ack) begin
        repeat ($urandom % 4) @(negedge clk);
        vram[vram_addr] = vram_wr_data;
        vram_wr_ack     = vram_wr_req;
      end
    end
  end

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    int waited;
    @(negedge clk);
    reg_num    = num;
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    waited     = 0;
    while (reg_wr_ack != reg_wr_req && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (reg_wr_ack != reg_wr_req) begin
      tb_errors++;
      $display("Register %0d write was never acknowledged", num);
    end
  endtask

  task automatic run_random_command();
    int         pick;
    int         nx_i;
    int         ny_i;
    int         sx_i;
    int         dx_i;
    logic [3:0] code;
    logic [3:0] op_bits;
    logic       dix;
    logic       diy;
    int         waited;
    pick = $urandom % 8;
    case (pick)
      0, 1:    code = CMD_HMMV;
      2:       code = CMD_LMMV;
      3, 4:    code = CMD_LMMM;
      5:       code = CMD_PSET;
      6:       code = CMD_POINT;
      // STOP or a dropped code
      default: code = ($urandom % 2 == 0) ? 4'h0 : 4'hA;
    endcase
    nx_i = 2 + $urandom % 8;
    ny_i = 1 + $urandom % 4;
    // Start near the right edge now and then
    sx_i = ($urandom % 4 == 0) ? 250 + $urandom % 6 : $urandom % 256;
    dx_i = ($urandom % 4 == 0) ? 250 + $urandom % 6 : $urandom % 256;
    dix  = 1'($urandom % 2);
    diy  = 1'($urandom % 2);
    op_bits = {1'($urandom % 4 == 0), 3'($urandom % 8)};
    deadline = cycle_count + nx_i * ny_i * 30 + 100;
    @(negedge clk);
    mode_8bpp = 1'($urandom % 2);
    write_reg(REG_SX_L, 8'(sx_i));
    write_reg(REG_SX_H, 8'h00);
    write_reg(REG_SY_L, 8'($urandom % 12));
    write_reg(REG_SY_H, 8'h00);
    write_reg(REG_DX_L, 8'(dx_i));
    write_reg(REG_DX_H, 8'h00);
    write_reg(REG_DY_L, 8'($urandom % 12));
    write_reg(REG_DY_H, 8'h00);
    write_reg(REG_NX_L, 8'(nx_i));
    write_reg(REG_NX_H, 8'h00);
    write_reg(REG_NY_L, 8'(ny_i));
    write_reg(REG_NY_H, 8'h00);
    write_reg(REG_CLR, 8'($urandom));
    write_reg(REG_ARG, {4'h0, diy, dix, 2'b00});
    write_reg(REG_CMD, {code, op_bits});
    waited = 0;
    while (!ce && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!ce) begin
      tb_errors++;
      $display("ce did not rise after command code %h", code);
    end
    // Upper nibble of the written command byte
    if (current_command != code) begin
      tb_errors++;
      $display("FAILED cmd%0d_current_command expected %h actual %h", cur_cmd, code,
               current_command);
    end
    while (ce) @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h2fd68ad8));
    reset        = 1'b1;
    mode_8bpp    = 1'b0;
    reg_wr_req   = 1'b0;
    reg_num      = '0;
    reg_data     = '0;
    vram_rd_ack  = 1'b0;
    vram_wr_ack  = 1'b0;
    vram_rd_data = '0;
    tb_errors    = 0;
    cur_cmd      = 0;
    for (int i = 0; i < 131072; i++) begin
      vram[i]         = 8'($urandom);
      u_chk.shadow[i] = vram[i];
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (ce) begin
      tb_errors++;
      $display("ce is set after reset with no command");
    end
    for (cur_cmd = 0; cur_cmd < NUM_CMDS; cur_cmd++) begin
      run_random_command();
    end
    repeat (4) @(negedge clk);
    $display("Commands: %0d, checks: %0d, checker errors: %0d, testbench errors: %0d",
             u_chk.cmd_count, u_chk.checks, u_chk.errors, tb_errors);
    if (tb_errors == 0 && u_chk.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tb_vdp_cmd_checker.sv
// Testbench checker for the drawing-command engine
// Snoops host writes, predicts every VRAM write over a shadow VRAM and compares

`timescale 1ns/1ps

module tb_vdp_cmd_checker
  import vdp_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       mode_8bpp,
  input  logic       reg_wr_ack,
  input  logic [3:0] reg_num,
  input  logic [7:0] reg_data,
  input  logic       vram_wr_req,
  input  vram_addr_t vram_addr,
  input  colour_t    vram_wr_data,
  input  logic       ce,
  input  colour_t    clr
);

  // Filled by the testbench top together with its VRAM
  colour_t    shadow [0:131071];
  int         errors;
  int         checks;
  int         cmd_count;
  int         wr_index;
  vram_addr_t exp_addr [$];
  colour_t    exp_data [$];

  // Host register copies
  logic [9:0] sx_s;
  logic [9:0] sy_s;
  logic [9:0] dx_s;
  logic [9:0] dy_s;
  logic [9:0] nx_s;
  logic [9:0] ny_s;
  logic       dix_s;
  logic       diy_s;
  logic [7:0] cmr_s;
  logic [3:0] run_cmd;
  colour_t    clr_m;
  logic       last_ack;
  logic       last_wr_req;
  logic       last_ce;

  function automatic string cmd_name(input logic [3:0] code);
    case (code)
      CMD_HMMV:  return "HMMV";
      CMD_LMMV:  return "LMMV";
      CMD_LMMM:  return "LMMM";
      CMD_PSET:  return "PSET";
      CMD_POINT: return "POINT";
      default:   return "OTHER";
    endcase
  endfunction

  // Two pixels per byte in four-bit mode
  function automatic vram_addr_t pixel_addr(input logic m8, input logic [9:0] x,
                                            input logic [9:0] y);
    if (m8) return {y[8:0], x[7:0]};
    return {y, x[7:1]};
  endfunction

  function automatic colour_t read_pixel(input logic m8, input logic [9:0] x,
                                         input logic [9:0] y);
    colour_t b;
    b = shadow[pixel_addr(m8, x, y)];
    if (m8) return b;
    // Odd x is the low nibble
    return x[0] ? {4'h0, b[3:0]} : {4'h0, b[7:4]};
  endfunction

  function automatic colour_t combine(input logic [7:0] op_bits, input logic m8,
                                      input colour_t src, input colour_t dst);
    colour_t s;
    s = src & (m8 ? COLMASK_8BPP : COLMASK_4BPP);
    // Transparent source
    if (op_bits[3] && s == 8'h00) return dst;
    case (op_bits[2:0])
      LOP_IMP: return s;
      LOP_AND: return s & dst;
      LOP_OR:  return s | dst;
      LOP_XOR: return s ^ dst;
      LOP_NOT: return ~s;
      default: return dst;
    endcase
  endfunction

  task automatic store_byte(input vram_addr_t a, input colour_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    shadow[a] = d;
  endtask

  task automatic store_pixel(input logic m8, input logic [9:0] x, input logic [9:0] y,
                             input colour_t val);
    vram_addr_t a;
    colour_t    b;
    a = pixel_addr(m8, x, y);
    b = shadow[a];
    if (m8) b = val;
    else if (x[0]) b = {b[7:4], val[3:0]};
    else b = {val[3:0], b[3:0]};
    store_byte(a, b);
  endtask

  task automatic predict_command();
    logic [9:0] xs;
    logic [9:0] xd;
    logic [9:0] ys;
    logic [9:0] yd;
    logic [9:0] nyc;
    logic [9:0] cnt;
    logic [9:0] cnt_init;
    logic [9:0] step;
    logic [9:0] ystep;
    logic       byte_mode;
    logic       is_copy;
    logic       row_done;
    logic       rect_done;
    colour_t    src;
    run_cmd = cmr_s[7:4];
    exp_addr.delete();
    exp_data.delete();
    wr_index = 0;
    if (run_cmd == CMD_POINT) begin
      clr_m = read_pixel(mode_8bpp, sx_s, sy_s);
      return;
    end
    if (run_cmd == CMD_PSET) begin
      store_pixel(mode_8bpp, dx_s, dy_s,
                  combine(cmr_s, mode_8bpp, clr_m, read_pixel(mode_8bpp, dx_s, dy_s)));
      return;
    end
    if (run_cmd != CMD_HMMV && run_cmd != CMD_LMMV && run_cmd != CMD_LMMM) return;
    // HMMV in four-bit mode walks bytes
    byte_mode = run_cmd == CMD_HMMV && !mode_8bpp;
    is_copy   = run_cmd == CMD_LMMM;
    cnt_init  = byte_mode ? {1'b0, nx_s[9:1]} : nx_s;
    step      = byte_mode ? 10'd2 : 10'd1;
    if (dix_s) step = 10'd0 - step;
    ystep     = diy_s ? 10'h3FF : 10'd1;
    ys        = sy_s;
    yd        = dy_s;
    nyc       = ny_s;
    rect_done = 1'b0;
    while (!rect_done) begin
      xs       = sx_s;
      xd       = dx_s;
      cnt      = cnt_init;
      row_done = 1'b0;
      // Each row does at least one element
      while (!row_done) begin
        if (run_cmd == CMD_HMMV) begin
          store_byte(pixel_addr(mode_8bpp, xd, yd), clr_m);
        end else begin
          src = clr_m;
          if (is_copy) begin
            src = read_pixel(mode_8bpp, xs, ys);
            xs  = xs + step;
          end
          store_pixel(mode_8bpp, xd, yd,
                      combine(cmr_s, mode_8bpp, src, read_pixel(mode_8bpp, xd, yd)));
        end
        xd       = xd + step;
        cnt      = cnt - 10'd1;
        row_done = cnt == 10'd0 || xd[8] || (is_copy && xs[8]);
      end
      rect_done = nyc == 10'd1 || (diy_s && yd == 10'd0) || (diy_s && is_copy && ys == 10'd0);
      nyc = nyc - 10'd1;
      ys  = ys + ystep;
      yd  = yd + ystep;
    end
  endtask

  task automatic capture_reg();
    case (reg_num)
      REG_SX_L: sx_s[7:0] = reg_data;
      REG_SX_H: sx_s[8]   = reg_data[0];
      REG_SY_L: sy_s[7:0] = reg_data;
      REG_SY_H: sy_s[9:8] = reg_data[1:0];
      REG_DX_L: dx_s[7:0] = reg_data;
      REG_DX_H: dx_s[8]   = reg_data[0];
      REG_DY_L: dy_s[7:0] = reg_data;
      REG_DY_H: dy_s[9:8] = reg_data[1:0];
      REG_NX_L: nx_s[7:0] = reg_data;
      REG_NX_H: nx_s[9:8] = reg_data[1:0];
      REG_NY_L: ny_s[7:0] = reg_data;
      REG_NY_H: ny_s[9:8] = reg_data[1:0];
      REG_CLR:  clr_m     = reg_data;
      REG_ARG: begin
        dix_s = reg_data[2];
        diy_s = reg_data[3];
      end
      REG_CMD: begin
        cmr_s = reg_data;
        predict_command();
      end
      default: ;
    endcase
  endtask

  task automatic check_write();
    vram_addr_t a;
    colour_t    d;
    string      name;
    checks++;
    if (exp_addr.size() == 0) begin
      errors++;
      $display("Unexpected VRAM write to %h in command %0d (%s)", vram_addr, cmd_count,
               cmd_name(run_cmd));
      return;
    end
    a    = exp_addr.pop_front();
    d    = exp_data.pop_front();
    name = $sformatf("cmd%0d_%s_write%0d", cmd_count, cmd_name(run_cmd), wr_index);
    if (vram_addr != a) begin
      errors++;
      $display("FAILED %s_addr expected %h actual %h", name, a, vram_addr);
    end
    if (vram_wr_data != d) begin
      errors++;
      $display("FAILED %s_data expected %h actual %h", name, d, vram_wr_data);
    end
    wr_index++;
  endtask

  task automatic finish_command();
    if (exp_addr.size() != 0) begin
      errors++;
      $display("Command %0d (%s) ended with %0d predicted VRAM writes missing", cmd_count,
               cmd_name(run_cmd), exp_addr.size());
    end
    if (run_cmd == CMD_POINT) begin
      checks++;
      if (clr != clr_m) begin
        errors++;
        $display("FAILED cmd%0d_POINT_clr expected %h actual %h", cmd_count, clr_m, clr);
      end
    end
    cmd_count++;
  endtask

  // All sampling on the falling edge, DUT outputs move on the rising edge
  initial begin
    errors      = 0;
    checks      = 0;
    cmd_count   = 0;
    wr_index    = 0;
    {sx_s, sy_s, dx_s, dy_s, nx_s, ny_s} = '0;
    dix_s       = 1'b0;
    diy_s       = 1'b0;
    cmr_s       = '0;
    run_cmd     = '0;
    clr_m       = '0;
    last_ack    = 1'b0;
    last_wr_req = 1'b0;
    last_ce     = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (reg_wr_ack != last_ack) capture_reg();
        if (vram_wr_req != last_wr_req) check_write();
        if (last_ce && !ce) finish_command();
      end
      last_ack    = reg_wr_ack;
      last_wr_req = vram_wr_req;
      last_ce     = ce;
    end
  end

endmodule

//--- vdp_cmd_props.sv
// Handshake assertions for the VRAM port, bound into every vdp_vram_port
// Address and data hold while a request is pending, one access at a time

`timescale 1ns/1ps

module vdp_cmd_props
  import vdp_cmd_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       vram_rd_req,
  input logic       vram_rd_ack,
  input logic       vram_wr_req,
  input logic       vram_wr_ack,
  input vram_addr_t vram_addr,
  input colour_t    vram_wr_data
);

  logic rd_pend;
  logic wr_pend;

  assign rd_pend = vram_rd_req != vram_rd_ack;
  assign wr_pend = vram_wr_req != vram_wr_ack;

  // Same request still open
  a_rd_hold: assert property (@(posedge clk) disable iff (reset)
    (rd_pend && $past(rd_pend) && $stable(vram_rd_req)) |-> $stable(vram_addr))
    else $error("VRAM read address changed while the read was pending");

  a_wr_hold: assert property (@(posedge clk) disable iff (reset)
    (wr_pend && $past(wr_pend) && $stable(vram_wr_req)) |->
    ($stable(vram_addr) && $stable(vram_wr_data)))
    else $error("VRAM write address or data changed while the write was pending");

  a_one_access: assert property (@(posedge clk) disable iff (reset) !(rd_pend && wr_pend))
    else $error("VRAM read and write pending together");

endmodule

bind vdp_vram_port vdp_cmd_props u_props (
  .clk          (clk),
  .reset        (reset),
  .vram_rd_req  (vram_rd_req),
  .vram_rd_ack  (vram_rd_ack),
  .vram_wr_req  (vram_wr_req),
  .vram_wr_ack  (vram_wr_ack),
  .vram_addr    (vram_addr),
  .vram_wr_data (vram_wr_data)
);

//--- vdp_cmd_top.sv
// Top level of the drawing-command engine
// Host register port in, toggle-handshake VRAM port out

`timescale 1ns/1ps

module vdp_cmd_top
  import vdp_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       mode_8bpp,
  input  logic       reg_wr_req,
  input  logic [3:0] reg_num,
  input  logic [7:0] reg_data,
  input  logic       vram_rd_ack,
  input  logic       vram_wr_ack,
  input  colour_t    vram_rd_data,
  output logic       reg_wr_ack,
  output logic       vram_rd_req,
  output logic       vram_wr_req,
  output vram_addr_t vram_addr,
  output colour_t    vram_wr_data,
  output logic       ce,
  output colour_t    clr,
  output logic [3:0] current_command
);

  logic       cmd_start;
  logic       clr_wr;
  coord_x_t   sx;
  coord_y_t   sy;
  coord_x_t   dx;
  coord_y_t   dy;
  count_t     nx;
  count_t     ny;
  colour_t    clr_reg;
  logic       dix;
  logic       diy;
  logic [7:0] cmr;
  logic       rd_go;
  logic       wr_go;
  coord_x_t   acc_x;
  coord_y_t   acc_y;
  colour_t    wr_byte;
  colour_t    src_latch;
  colour_t    src_point;
  colour_t    merged_byte;
  logic       access_done;
  logic       x_low;

  assign current_command = cmr[7:4];

  vdp_cmd_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .reg_wr_ack (reg_wr_ack),
    .cmd_start  (cmd_start),
    .clr_wr     (clr_wr),
    .sx         (sx),
    .sy         (sy),
    .dx         (dx),
    .dy         (dy),
    .nx         (nx),
    .ny         (ny),
    .clr_reg    (clr_reg),
    .dix        (dix),
    .diy        (diy),
    .cmr        (cmr)
  );

  vdp_cmd_engine u_engine (
    .clk         (clk),
    .reset       (reset),
    .mode_8bpp   (mode_8bpp),
    .cmd_start   (cmd_start),
    .clr_wr      (clr_wr),
    .sx          (sx),
    .sy          (sy),
    .dx          (dx),
    .dy          (dy),
    .nx          (nx),
    .ny          (ny),
    .clr_reg     (clr_reg),
    .dix         (dix),
    .diy         (diy),
    .cmr         (cmr),
    .access_done (access_done),
    .src_point   (src_point),
    .merged_byte (merged_byte),
    .ce          (ce),
    .clr         (clr),
    .rd_go       (rd_go),
    .wr_go       (wr_go),
    .acc_x       (acc_x),
    .acc_y       (acc_y),
    .wr_byte     (wr_byte),
    .src_latch   (src_latch)
  );

  // Source pixel for the operation comes from the engine latch
  vdp_pixel_alu u_alu (
    .mode_8bpp   (mode_8bpp),
    .cmr         (cmr),
    .x_low       (x_low),
    .rd_byte     (vram_rd_data),
    .src_colour  (src_latch),
    .src_point   (src_point),
    .merged_byte (merged_byte)
  );

  vdp_vram_port u_port (
    .clk          (clk),
    .reset        (reset),
    .mode_8bpp    (mode_8bpp),
    .rd_go        (rd_go),
    .wr_go        (wr_go),
    .acc_x        (acc_x),
    .acc_y        (acc_y),
    .wr_byte      (wr_byte),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_req  (vram_rd_req),
    .vram_wr_req  (vram_wr_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .access_done  (access_done),
    .x_low        (x_low)
  );

endmodule

//--- vdp_vram_port.sv
// VRAM request side of the engine
// Forms the byte address per mode, flips the toggle requests and flags completion

`timescale 1ns/1ps

module vdp_vram_port
  import vdp_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       mode_8bpp,
  input  logic       rd_go,
  input  logic       wr_go,
  input  coord_x_t   acc_x,
  input  coord_y_t   acc_y,
  input  colour_t    wr_byte,
  input  logic       vram_rd_ack,
  input  logic       vram_wr_ack,
  output logic       vram_rd_req,
  output logic       vram_wr_req,
  output vram_addr_t vram_addr,
  output colour_t    vram_wr_data,
  output logic       access_done,
  output logic       x_low
);

  vram_addr_t addr_next;
  logic       rd_busy;
  logic       wr_busy;
  logic       rd_done;
  logic       wr_done;

  // Four-bit mode packs two pixels per byte
  assign addr_next = mode_8bpp ? {acc_y[8:0], acc_x[7:0]} : {acc_y, acc_x[7:1]};

  assign rd_done     = rd_busy && (vram_rd_req == vram_rd_ack);
  assign wr_done     = wr_busy && (vram_wr_req == vram_wr_ack);
  assign access_done = rd_done || wr_done;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vram_rd_req  <= 1'b0;
      vram_wr_req  <= 1'b0;
      vram_addr    <= '0;
      vram_wr_data <= '0;
      x_low        <= 1'b0;
      rd_busy      <= 1'b0;
      wr_busy      <= 1'b0;
    end else begin
      if (rd_done) rd_busy <= 1'b0;
      if (wr_done) wr_busy <= 1'b0;
      // Address and data held until ack catches up
      if (rd_go) begin
        vram_addr   <= addr_next;
        x_low       <= acc_x[0];
        vram_rd_req <= ~vram_rd_ack;
        rd_busy     <= 1'b1;
      end
      if (wr_go) begin
        vram_addr    <= addr_next;
        vram_wr_data <= wr_byte;
        vram_wr_req  <= ~vram_wr_ack;
        wr_busy      <= 1'b1;
      end
    end
  end

endmodule

//--- vdp_pixel_alu.sv
// Pixel logic between the engine and the VRAM read data
// Extracts the addressed pixel, applies the logical operation and merges the result back

`timescale 1ns/1ps

module vdp_pixel_alu
  import vdp_cmd_pkg::*;
(
  input  logic       mode_8bpp,
  input  logic [7:0] cmr,
  input  logic       x_low,
  input  colour_t    rd_byte,
  input  colour_t    src_colour,
  output colour_t    src_point,
  output colour_t    merged_byte
);

  colour_t colmask;
  colour_t rd_point;
  colour_t src_m;
  colour_t result;

  assign colmask = mode_8bpp ? COLMASK_8BPP : COLMASK_4BPP;

  // Odd x sits in the low nibble
  always_comb begin
    if (mode_8bpp) begin
      rd_point = rd_byte;
    end else if (x_low) begin
      rd_point = {4'h0, rd_byte[3:0]};
    end else begin
      rd_point = {4'h0, rd_byte[7:4]};
    end
  end

  assign src_point = rd_point;
  assign src_m     = src_colour & colmask;

  always_comb begin
    // Transparent source keeps the destination
    if (!cmr[3] || src_m != '0) begin
      case (log_op_t'(cmr[2:0]))
        LOP_IMP: result = src_m;
        LOP_AND: result = src_m & rd_point;
        LOP_OR:  result = src_m | rd_point;
        LOP_XOR: result = src_m ^ rd_point;
        LOP_NOT: result = ~src_m;
        default: result = rd_point;
      endcase
    end else begin
      result = rd_point;
    end
  end

  // Other nibble passes through unchanged
  always_comb begin
    if (mode_8bpp) begin
      merged_byte = result;
    end else if (x_low) begin
      merged_byte = {rd_byte[7:4], result[3:0]};
    end else begin
      merged_byte = {result[3:0], rd_byte[3:0]};
    end
  end

endmodule

//--- vdp_cmd_engine.sv
// Command sequencer for HMMV, LMMV, LMMM, PSET and POINT
// Walks the rectangle with working copies of the coordinates and issues VRAM accesses

`timescale 1ns/1ps

module vdp_cmd_engine
  import vdp_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       mode_8bpp,
  input  logic       cmd_start,
  input  logic       clr_wr,
  input  coord_x_t   sx,
  input  coord_y_t   sy,
  input  coord_x_t   dx,
  input  coord_y_t   dy,
  input  count_t     nx,
  input  count_t     ny,
  input  colour_t    clr_reg,
  input  logic       dix,
  input  logic       diy,
  input  logic [7:0] cmr,
  input  logic       access_done,
  input  colour_t    src_point,
  input  colour_t    merged_byte,
  output logic       ce,
  output colour_t    clr,
  output logic       rd_go,
  output logic       wr_go,
  output coord_x_t   acc_x,
  output coord_y_t   acc_y,
  output colour_t    wr_byte,
  output colour_t    src_latch
);

  engine_state_t state;
  cmd_code_t     cmd;
  logic          byte_cmd;
  colour_t       colmask;
  coord_x_t      x_step;
  coord_y_t      y_step;
  count_t        nx_count;

  // Working copies so the host registers stay untouched
  coord_x_t sx_w;
  coord_x_t dx_w;
  coord_y_t sy_w;
  coord_y_t dy_w;
  count_t   ny_w;
  count_t   x_cnt;
  logic     first_pass;
  // One access outstanding at the port even across an abort
  logic     acc_pend;
  logic     row_end;
  logic     rect_end;

  assign cmd      = cmd_code_t'(cmr[7:4]);
  assign byte_cmd = cmr[7:6] == 2'b11;
  assign colmask  = (byte_cmd || mode_8bpp) ? COLMASK_8BPP : COLMASK_4BPP;

  // HMMV moves a byte of two pixels in four-bit mode
  always_comb begin
    if (byte_cmd && !mode_8bpp) begin
      x_step   = dix ? 10'h3FE : 10'd2;
      nx_count = {1'b0, nx[9:1]};
    end else begin
      x_step   = dix ? 10'h3FF : 10'd1;
      nx_count = nx;
    end
  end

  assign y_step = diy ? 10'h3FF : 10'd1;

  always_comb begin
    case (cmd)
      CMD_HMMV, CMD_LMMV: row_end = (x_cnt == '0) || dx_w[8];
      CMD_LMMM:           row_end = (x_cnt == '0) || sx_w[8] || dx_w[8];
      default:            row_end = 1'b1;
    endcase
  end

  // Last row or the upward walk hit row 0
  assign rect_end = (ny_w == 10'd1) || (diy && dy_w == '0) ||
                    (diy && cmd == CMD_LMMM && sy_w == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_pend <= 1'b0;
    end else if (rd_go || wr_go) begin
      acc_pend <= 1'b1;
    end else if (access_done) begin
      acc_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= ST_IDLE;
      ce         <= 1'b0;
      clr        <= '0;
      rd_go      <= 1'b0;
      wr_go      <= 1'b0;
      acc_x      <= '0;
      acc_y      <= '0;
      wr_byte    <= '0;
      src_latch  <= '0;
      sx_w       <= '0;
      dx_w       <= '0;
      sy_w       <= '0;
      dy_w       <= '0;
      ny_w       <= '0;
      x_cnt      <= '0;
      first_pass <= 1'b0;
    end else begin
      rd_go <= 1'b0;
      wr_go <= 1'b0;
      if (cmd_start) begin
        // Load working copies and restart
        sx_w       <= sx;
        dx_w       <= dx;
        sy_w       <= sy;
        dy_w       <= dy;
        ny_w       <= ny;
        x_cnt      <= nx_count;
        first_pass <= 1'b1;
        ce         <= 1'b1;
        state      <= ST_CHK_LOOP;
      end else begin
        case (state)
          ST_IDLE: ce <= 1'b0;
          ST_CHK_LOOP: begin
            first_pass <= 1'b0;
            if (!first_pass && row_end && rect_end) begin
              ce    <= 1'b0;
              state <= ST_IDLE;
            end else begin
              // Next row
              if (!first_pass && row_end) begin
                sx_w  <= sx;
                dx_w  <= dx;
                x_cnt <= nx_count;
                ny_w  <= ny_w - 10'd1;
                sy_w  <= sy_w + y_step;
                dy_w  <= dy_w + y_step;
              end
              case (cmd)
                CMD_HMMV: begin
                  wr_byte <= clr;
                  state   <= ST_WR_DST;
                end
                CMD_LMMV, CMD_PSET: begin
                  src_latch <= clr;
                  state     <= ST_RD_DST;
                end
                CMD_LMMM, CMD_POINT: state <= ST_RD_SRC;
                // STOP and unknown codes end without VRAM access
                default: begin
                  ce    <= 1'b0;
                  state <= ST_IDLE;
                end
              endcase
            end
          end
          ST_RD_SRC: begin
            if (!acc_pend) begin
              acc_x <= sx_w;
              acc_y <= sy_w;
              rd_go <= 1'b1;
              state <= ST_WAIT_SRC;
            end
          end
          ST_WAIT_SRC: begin
            if (access_done) begin
              if (cmd == CMD_POINT) begin
                clr   <= src_point;
                ce    <= 1'b0;
                state <= ST_IDLE;
              end else begin
                src_latch <= src_point;
                sx_w      <= sx_w + x_step;
                state     <= ST_RD_DST;
              end
            end
          end
          ST_RD_DST: begin
            if (!acc_pend) begin
              acc_x <= dx_w;
              acc_y <= dy_w;
              rd_go <= 1'b1;
              state <= ST_WAIT_DST;
            end
          end
          ST_WAIT_DST: begin
            // Operation result already merged into the read byte
            if (access_done) begin
              wr_byte <= merged_byte;
              state   <= ST_WR_DST;
            end
          end
          ST_WR_DST: begin
            if (!acc_pend) begin
              acc_x <= dx_w;
              acc_y <= dy_w;
              wr_go <= 1'b1;
              state <= ST_WAIT_WR;
            end
          end
          ST_WAIT_WR: begin
            if (access_done) begin
              if (cmd == CMD_PSET) begin
                ce    <= 1'b0;
                state <= ST_IDLE;
              end else begin
                dx_w  <= dx_w + x_step;
                x_cnt <= x_cnt - 10'd1;
                state <= ST_CHK_LOOP;
              end
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
      // Host colour write is masked to pixel size while a command runs
      if (clr_wr) begin
        clr <= ce ? (clr_reg & colmask) : clr_reg;
      end
    end
  end

endmodule

//--- vdp_cmd_regs.sv
// Host-visible command registers
// Toggle write handshake, one write per flip of reg_wr_req; a CMD write pulses cmd_start

`timescale 1ns/1ps

module vdp_cmd_regs
  import vdp_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       reg_wr_req,
  input  logic [3:0] reg_num,
  input  logic [7:0] reg_data,
  output logic       reg_wr_ack,
  output logic       cmd_start,
  output logic       clr_wr,
  output coord_x_t   sx,
  output coord_y_t   sy,
  output coord_x_t   dx,
  output coord_y_t   dy,
  output count_t     nx,
  output count_t     ny,
  output colour_t    clr_reg,
  output logic       dix,
  output logic       diy,
  output logic [7:0] cmr
);

  logic wr_pending;

  // Request pending while the toggles differ
  assign wr_pending = reg_wr_req != reg_wr_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
      clr_wr     <= 1'b0;
      sx         <= '0;
      sy         <= '0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr_reg    <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmr        <= '0;
    end else begin
      // Strobes last one cycle
      cmd_start <= 1'b0;
      clr_wr    <= 1'b0;
      if (wr_pending) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_SX_L: sx[7:0] <= reg_data;
          // X high bytes hold a single bit
          REG_SX_H: sx[8]   <= reg_data[0];
          REG_SY_L: sy[7:0] <= reg_data;
          REG_SY_H: sy[9:8] <= reg_data[1:0];
          REG_DX_L: dx[7:0] <= reg_data;
          REG_DX_H: dx[8]   <= reg_data[0];
          REG_DY_L: dy[7:0] <= reg_data;
          REG_DY_H: dy[9:8] <= reg_data[1:0];
          REG_NX_L: nx[7:0] <= reg_data;
          REG_NX_H: nx[9:8] <= reg_data[1:0];
          REG_NY_L: ny[7:0] <= reg_data;
          REG_NY_H: ny[9:8] <= reg_data[1:0];
          REG_CLR: begin
            clr_reg <= reg_data;
            clr_wr  <= 1'b1;
          end
          REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          // New command aborts whatever runs
          REG_CMD: begin
            cmr       <= reg_data;
            cmd_start <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- vdp_cmd_pkg.sv
// Shared definitions for the drawing-command engine
// Command and operation codes, sequencer states, register numbers and vector types

package vdp_cmd_pkg;

  // Widths that carry a meaning
  typedef logic [16:0] vram_addr_t;
  // Bit 8 set means past the right edge
  typedef logic [9:0]  coord_x_t;
  typedef logic [9:0]  coord_y_t;
  typedef logic [9:0]  count_t;
  typedef logic [7:0]  colour_t;

  // Upper nibble of the command register
  typedef enum logic [3:0] {
    CMD_STOP  = 4'b0000,
    CMD_POINT = 4'b0100,
    CMD_PSET  = 4'b0101,
    CMD_LMMV  = 4'b1000,
    CMD_LMMM  = 4'b1001,
    CMD_HMMV  = 4'b1100
  } cmd_code_t;

  // Low three bits of the command register, codes 5 to 7 keep the destination
  typedef enum logic [2:0] {
    LOP_IMP = 3'b000,
    LOP_AND = 3'b001,
    LOP_OR  = 3'b010,
    LOP_XOR = 3'b011,
    LOP_NOT = 3'b100
  } log_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHK_LOOP,
    ST_RD_SRC,
    ST_WAIT_SRC,
    ST_RD_DST,
    ST_WAIT_DST,
    ST_WR_DST,
    ST_WAIT_WR
  } engine_state_t;

  // Host register numbers
  localparam logic [3:0] REG_SX_L = 4'd0;
  localparam logic [3:0] REG_SX_H = 4'd1;
  localparam logic [3:0] REG_SY_L = 4'd2;
  localparam logic [3:0] REG_SY_H = 4'd3;
  localparam logic [3:0] REG_DX_L = 4'd4;
  localparam logic [3:0] REG_DX_H = 4'd5;
  localparam logic [3:0] REG_DY_L = 4'd6;
  localparam logic [3:0] REG_DY_H = 4'd7;
  localparam logic [3:0] REG_NX_L = 4'd8;
  localparam logic [3:0] REG_NX_H = 4'd9;
  localparam logic [3:0] REG_NY_L = 4'd10;
  localparam logic [3:0] REG_NY_H = 4'd11;
  localparam logic [3:0] REG_CLR  = 4'd12;
  localparam logic [3:0] REG_ARG  = 4'd13;
  localparam logic [3:0] REG_CMD  = 4'd14;

  // Colour masks per pixel size
  localparam colour_t COLMASK_4BPP = 8'h0F;
  localparam colour_t COLMASK_8BPP = 8'hFF;

endpackage
